// ==== common/mips_pkg.sv ====
package mips_pkg;

    // data word and byte address
    typedef logic [31:0] word_t;

    // architectural register number
    typedef logic [4:0] reg_addr_t;

    // operation selected by decode for the execute ALU
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD = 4'h0;
    localparam alu_op_t ALU_SUB = 4'h1;
    localparam alu_op_t ALU_AND = 4'h2;
    localparam alu_op_t ALU_OR  = 4'h3;
    localparam alu_op_t ALU_XOR = 4'h4;
    localparam alu_op_t ALU_SLT = 4'h5;
    localparam alu_op_t ALU_LUI = 4'h6;
    localparam alu_op_t ALU_BEQ = 4'h7;
    localparam alu_op_t ALU_BNE = 4'h8;
    // unsupported encodings retire through this code
    localparam alu_op_t ALU_NOP = 4'hf;

    // primary opcode field, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // funct field of SPECIAL, instr[5:0]
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    // boot vector in kseg1
    localparam word_t RESET_PC = 32'hbfc0_0000;

    // instruction fetch FSM
    // F_REQ: request outstanding on the correct path
    // F_KILL: outstanding request was issued before a redirect, its reply is dropped
    typedef enum logic {
        F_REQ,
        F_KILL
    } fetch_state_t;

endpackage

// ==== common/issue_if.sv ====
`timescale 1ns/1ps

// contents of the decode/execute register
interface issue_if;

    logic                 valid;
    mips_pkg::word_t      pc;
    mips_pkg::alu_op_t    op;
    mips_pkg::reg_addr_t  dest;
    logic                 wen;
    mips_pkg::word_t      src_a;
    mips_pkg::word_t      src_b;
    // already sign or zero extended by decode
    mips_pkg::word_t      imm;
    logic                 use_imm;

    modport source (
        output valid, pc, op, dest, wen, src_a, src_b, imm, use_imm
    );

    modport sink (
        input valid, pc, op, dest, wen, src_a, src_b, imm, use_imm
    );

endinterface

// ==== common/retire_if.sv ====
`timescale 1ns/1ps

// retire register, doubles as the regfile write port
interface retire_if;

    logic                 valid;
    mips_pkg::word_t      pc;
    logic                 wen;
    mips_pkg::reg_addr_t  waddr;
    mips_pkg::word_t      wdata;

    modport source (
        output valid, pc, wen, waddr, wdata
    );

    modport sink (
        input valid, pc, wen, waddr, wdata
    );

endinterface

// ==== fetch/fetch.sv ====
`timescale 1ns/1ps

module fetch (
    input  logic             clk,
    input  logic             rst_n,
    output logic             imem_req,
    output mips_pkg::word_t  imem_addr,
    input  logic             imem_data_ok,
    input  mips_pkg::word_t  imem_data,
    input  logic             redirect,
    input  mips_pkg::word_t  redirect_pc,
    output logic             fetch_valid,
    output mips_pkg::word_t  fetch_pc,
    output mips_pkg::word_t  fetch_instr
);

    mips_pkg::fetch_state_t state;
    mips_pkg::word_t        pc;
    mips_pkg::word_t        kill_pc;
    logic                   req_on;
    logic                   rsp;

    // request held from the first cycle out of reset
    assign imem_req  = req_on;
    assign imem_addr = pc;
    assign rsp       = req_on && imem_data_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_on      <= 1'b0;
            state       <= mips_pkg::F_REQ;
            pc          <= mips_pkg::RESET_PC;
            fetch_valid <= 1'b0;
        end else begin
            req_on      <= 1'b1;
            fetch_valid <= 1'b0;
            case (state)
                mips_pkg::F_REQ: begin
                    if (rsp) begin
                        // reply in the redirect cycle is wrong path
                        fetch_valid <= !redirect;
                        pc          <= redirect ? redirect_pc : pc + 32'd4;
                    end else if (redirect) begin
                        state <= mips_pkg::F_KILL;
                    end
                end
                mips_pkg::F_KILL: begin
                    // swallow the stale reply, then restart at the target
                    if (rsp) begin
                        state <= mips_pkg::F_REQ;
                        pc    <= redirect ? redirect_pc : kill_pc;
                    end
                end
                default: begin
                    state <= mips_pkg::F_REQ;
                end
            endcase
        end
    end

    // returned word and the address it came from
    always_ff @(posedge clk) begin
        if (rsp) begin
            fetch_pc    <= pc;
            fetch_instr <= imem_data;
        end
    end

    // target held while a stale reply is pending
    always_ff @(posedge clk) begin
        if (redirect) begin
            kill_pc <= redirect_pc;
        end
    end

    // address must not move until the slave answers
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (imem_req && !imem_data_ok) |=> (imem_req && $stable(imem_addr)))
        else $error("imem_addr changed while a request was waiting");

endmodule

// ==== decode/decode.sv ====
`timescale 1ns/1ps

module decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fetch_valid,
    input  mips_pkg::word_t      fetch_pc,
    input  mips_pkg::word_t      fetch_instr,
    input  logic                 redirect,
    output mips_pkg::reg_addr_t  rs_addr,
    output mips_pkg::reg_addr_t  rt_addr,
    input  mips_pkg::word_t      rs_data,
    input  mips_pkg::word_t      rt_data,
    input  logic                 ex_wen,
    input  mips_pkg::reg_addr_t  ex_dest,
    input  mips_pkg::word_t      ex_result,
    retire_if.sink               rt,
    issue_if.source              iss
);

    logic [5:0]           opcode;
    logic [5:0]           funct;
    logic [15:0]          imm16;
    mips_pkg::reg_addr_t  rd_addr;

    mips_pkg::alu_op_t    dec_op;
    mips_pkg::reg_addr_t  dec_dest;
    logic                 dec_wen;
    logic                 dec_use_imm;
    mips_pkg::word_t      dec_imm;
    mips_pkg::word_t      fwd_a;
    mips_pkg::word_t      fwd_b;

    assign opcode  = fetch_instr[31:26];
    assign rs_addr = fetch_instr[25:21];
    assign rt_addr = fetch_instr[20:16];
    assign rd_addr = fetch_instr[15:11];
    assign imm16   = fetch_instr[15:0];
    assign funct   = fetch_instr[5:0];

    always_comb begin
        dec_op      = mips_pkg::ALU_NOP;
        dec_dest    = '0;
        dec_wen     = 1'b0;
        dec_use_imm = 1'b0;
        dec_imm     = {{16{imm16[15]}}, imm16};
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                case (funct)
                    mips_pkg::FN_ADDU: dec_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: dec_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  dec_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   dec_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  dec_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  dec_op = mips_pkg::ALU_SLT;
                    default:           dec_op = mips_pkg::ALU_NOP;
                endcase
                dec_dest = rd_addr;
                dec_wen  = (dec_op != mips_pkg::ALU_NOP) && (rd_addr != '0);
            end
            mips_pkg::OP_ADDIU: begin
                dec_op      = mips_pkg::ALU_ADD;
                dec_dest    = rt_addr;
                dec_wen     = (rt_addr != '0);
                dec_use_imm = 1'b1;
            end
            mips_pkg::OP_ORI, mips_pkg::OP_LUI: begin
                dec_op      = (opcode == mips_pkg::OP_ORI) ? mips_pkg::ALU_OR
                                                           : mips_pkg::ALU_LUI;
                dec_dest    = rt_addr;
                dec_wen     = (rt_addr != '0);
                dec_use_imm = 1'b1;
                dec_imm     = {16'h0000, imm16};
            end
            mips_pkg::OP_BEQ: dec_op = mips_pkg::ALU_BEQ;
            mips_pkg::OP_BNE: dec_op = mips_pkg::ALU_BNE;
            default: begin
            end
        endcase
    end

    // youngest producer wins and r0 always comes from the regfile
    function automatic mips_pkg::word_t forward(input mips_pkg::reg_addr_t addr,
                                                input mips_pkg::word_t rf_val);
        forward = rf_val;
        if (addr != '0) begin
            if (ex_wen && (ex_dest == addr)) begin
                forward = ex_result;
            end else if (rt.valid && rt.wen && (rt.waddr == addr)) begin
                forward = rt.wdata;
            end
        end
    endfunction

    always_comb begin
        fwd_a = forward(rs_addr, rs_data);
        fwd_b = forward(rt_addr, rt_data);
    end

    // issue slot is emptied by a taken branch in execute
    always_ff @(posedge clk) begin
        if (!rst_n || redirect) begin
            iss.valid <= 1'b0;
        end else begin
            iss.valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            iss.pc      <= fetch_pc;
            iss.op      <= dec_op;
            iss.dest    <= dec_dest;
            iss.wen     <= dec_wen;
            iss.src_a   <= fwd_a;
            iss.src_b   <= fwd_b;
            iss.imm     <= dec_imm;
            iss.use_imm <= dec_use_imm;
        end
    end

endmodule

// ==== execute/execute.sv ====
`timescale 1ns/1ps

module execute (
    input  logic                 clk,
    input  logic                 rst_n,
    issue_if.sink                iss,
    output logic                 ex_wen,
    output mips_pkg::reg_addr_t  ex_dest,
    output mips_pkg::word_t      ex_result,
    output logic                 redirect,
    output mips_pkg::word_t      redirect_pc,
    retire_if.source             rt
);

    mips_pkg::word_t  opb;
    mips_pkg::word_t  result;
    logic             equal;
    logic             is_branch;

    assign opb = iss.use_imm ? iss.imm : iss.src_b;

    always_comb begin
        case (iss.op)
            mips_pkg::ALU_ADD: result = iss.src_a + opb;
            mips_pkg::ALU_SUB: result = iss.src_a - opb;
            mips_pkg::ALU_AND: result = iss.src_a & opb;
            mips_pkg::ALU_OR:  result = iss.src_a | opb;
            mips_pkg::ALU_XOR: result = iss.src_a ^ opb;
            mips_pkg::ALU_SLT: result = {31'b0, ($signed(iss.src_a) < $signed(opb))};
            mips_pkg::ALU_LUI: result = {opb[15:0], 16'h0000};
            default:           result = '0;
        endcase
    end

    // in-flight result for decode
    assign ex_wen    = iss.valid && iss.wen;
    assign ex_dest   = iss.dest;
    assign ex_result = result;

    // branches compare registers, never the immediate
    assign equal     = (iss.src_a == iss.src_b);
    assign is_branch = (iss.op == mips_pkg::ALU_BEQ) || (iss.op == mips_pkg::ALU_BNE);
    assign redirect  = iss.valid && (((iss.op == mips_pkg::ALU_BEQ) && equal) ||
                                     ((iss.op == mips_pkg::ALU_BNE) && !equal));

    // no delay slot, target relative to the branch itself
    assign redirect_pc = iss.pc + 32'd4 + {iss.imm[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rt.valid <= 1'b0;
            rt.wen   <= 1'b0;
        end else begin
            rt.valid <= iss.valid;
            rt.wen   <= ex_wen;
        end
    end

    always_ff @(posedge clk) begin
        rt.pc    <= iss.pc;
        rt.waddr <= iss.dest;
        rt.wdata <= result;
    end

    // taken branch retires without a write while decode empties the issue slot
    a_redirect_branch: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> is_branch ##1 (rt.valid && !rt.wen && !iss.valid))
        else $error("redirect without a retiring branch");

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_pkg::reg_addr_t  rs_addr,
    input  mips_pkg::reg_addr_t  rt_addr,
    output mips_pkg::word_t      rs_data,
    output mips_pkg::word_t      rt_data,
    retire_if.sink               rt
);

    mips_pkg::word_t  regs [0:31];
    logic             wr_en;

    assign wr_en = rt.valid && rt.wen && (rt.waddr != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rt.waddr] <= rt.wdata;
        end
    end

    // write-through so a same-cycle read sees the retiring value
    function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t addr);
        if (addr == '0) begin
            read_port = '0;
        end else if (wr_en && (rt.waddr == addr)) begin
            read_port = rt.wdata;
        end else begin
            read_port = regs[addr];
        end
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

endmodule

// ==== verilog/datapath.sv ====
`timescale 1ns/1ps

module datapath (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 imem_req,
    output mips_pkg::word_t      imem_addr,
    input  logic                 imem_data_ok,
    input  mips_pkg::word_t      imem_data,
    output logic                 rt_valid,
    output mips_pkg::word_t      rt_pc,
    output logic                 rf_wen,
    output mips_pkg::reg_addr_t  rf_waddr,
    output mips_pkg::word_t      rf_wdata,
    output logic                 flush_ex
);

    logic                 fetch_valid;
    mips_pkg::word_t      fetch_pc;
    mips_pkg::word_t      fetch_instr;
    logic                 redirect;
    mips_pkg::word_t      redirect_pc;
    mips_pkg::reg_addr_t  rs_addr;
    mips_pkg::reg_addr_t  rt_addr;
    mips_pkg::word_t      rs_data;
    mips_pkg::word_t      rt_data;
    logic                 ex_wen;
    mips_pkg::reg_addr_t  ex_dest;
    mips_pkg::word_t      ex_result;

    issue_if  iss_bus ();
    retire_if rt_bus ();

    fetch i_fetch (.clk, .rst_n,
                   .imem_req, .imem_addr, .imem_data_ok, .imem_data,
                   .redirect, .redirect_pc,
                   .fetch_valid, .fetch_pc, .fetch_instr);

    decode i_decode (.clk, .rst_n,
                     .fetch_valid, .fetch_pc, .fetch_instr,
                     .redirect,
                     .rs_addr, .rt_addr, .rs_data, .rt_data,
                     .ex_wen, .ex_dest, .ex_result,
                     .rt(rt_bus), .iss(iss_bus));

    execute i_execute (.clk, .rst_n,
                       .iss(iss_bus),
                       .ex_wen, .ex_dest, .ex_result,
                       .redirect, .redirect_pc,
                       .rt(rt_bus));

    regfile i_regfile (.clk, .rst_n,
                       .rs_addr, .rt_addr, .rs_data, .rt_data,
                       .rt(rt_bus));

    // retire trace
    assign rt_valid = rt_bus.valid;
    assign rt_pc    = rt_bus.pc;
    assign rf_wen   = rt_bus.wen;
    assign rf_waddr = rt_bus.waddr;
    assign rf_wdata = rt_bus.wdata;
    assign flush_ex = redirect;

endmodule

// ==== tb/imem_model.sv ====
`timescale 1ns/1ps

// instruction memory slave, one reply per request after 1 to max_lat cycles
module imem_model (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req,
    input  mips_pkg::word_t  addr,
    output logic             data_ok,
    output mips_pkg::word_t  data
);

    // program words from RESET_PC upward, written by the testbench
    mips_pkg::word_t  mem [0:255];
    // upper bound on reply latency, set per test
    int               max_lat;
    int               lat;
    int               waited;

    initial begin
        data_ok = 1'b0;
        data    = '0;
        lat     = 1;
        waited  = 0;
    end

    // outside the program the bus returns zero, which decodes as a no-op
    function automatic mips_pkg::word_t read_word(input mips_pkg::word_t a);
        mips_pkg::word_t offset;
        offset = (a - mips_pkg::RESET_PC) >> 2;
        if (offset < 32'd256) begin
            read_word = mem[offset[7:0]];
        end else begin
            read_word = '0;
        end
    endfunction

    always @(posedge clk) begin
        data_ok <= 1'b0;
        if (!rst_n) begin
            lat    <= 1;
            waited <= 0;
        end else if (req && !data_ok) begin
            if (waited + 1 >= lat) begin
                data_ok <= 1'b1;
                data    <= read_word(addr);
                waited  <= 0;
                // latency of the next request
                lat     <= 1 + int'($urandom % max_lat);
            end else begin
                waited <= waited + 1;
            end
        end
    end

endmodule

// ==== tb/tb_datapath.sv ====
`timescale 1ns/1ps

module tb_datapath;

    logic                 clk;
    logic                 rst_n;
    logic                 imem_req;
    mips_pkg::word_t      imem_addr;
    logic                 imem_data_ok;
    mips_pkg::word_t      imem_data;
    logic                 rt_valid;
    mips_pkg::word_t      rt_pc;
    logic                 rf_wen;
    mips_pkg::reg_addr_t  rf_waddr;
    mips_pkg::word_t      rf_wdata;
    logic                 flush_ex;

    // expected retire list built by the ISA model
    mips_pkg::word_t      exp_pc [$];
    logic                 exp_wen [$];
    mips_pkg::reg_addr_t  exp_waddr [$];
    mips_pkg::word_t      exp_wdata [$];
    int                   exp_flushes;
    int                   flush_count;
    int                   prog_len;

    datapath i_dut (.clk, .rst_n, .imem_req, .imem_addr, .imem_data_ok, .imem_data,
                    .rt_valid, .rt_pc, .rf_wen, .rf_waddr, .rf_wdata, .flush_ex);

    imem_model i_imem (.clk, .rst_n, .req(imem_req), .addr(imem_addr),
                       .data_ok(imem_data_ok), .data(imem_data));

    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (rst_n && flush_ex) begin
            flush_count++;
        end
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_word(input mips_pkg::word_t got, input mips_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(input mips_pkg::reg_addr_t got, input mips_pkg::reg_addr_t exp,
                             input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is r%0d, expected r%0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    function automatic mips_pkg::word_t rtype_word(input logic [5:0] funct,
            input mips_pkg::reg_addr_t rd, input mips_pkg::reg_addr_t rs,
            input mips_pkg::reg_addr_t rt);
        rtype_word = {mips_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic mips_pkg::word_t itype_word(input logic [5:0] op,
            input mips_pkg::reg_addr_t rt, input mips_pkg::reg_addr_t rs,
            input logic [15:0] imm);
        itype_word = {op, rs, rt, imm};
    endfunction

    task automatic clear_memory();
        for (int i = 0; i < 256; i++) begin
            i_imem.mem[i] = '0;
        end
        prog_len = 0;
    endtask

    task automatic emit(input mips_pkg::word_t w);
        i_imem.mem[prog_len] = w;
        prog_len++;
    endtask

    task automatic check_idle();
        check_bit(imem_req, 1'b0, "imem_req during reset");
        check_bit(rt_valid, 1'b0, "rt_valid during reset");
        check_bit(flush_ex, 1'b0, "flush_ex during reset");
    endtask

    // two cycles of reset, then the first request must carry the boot vector
    task automatic reset_dut();
        int cycles;
        @(posedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_idle();
        @(posedge clk);
        rst_n <= 1'b1;
        flush_count = 0;
        @(negedge clk);
        check_idle();
        cycles = 0;
        while (!imem_req) begin
            cycles++;
            if (cycles > 4) begin
                $display("timeout: imem_req never rose after reset");
                abort_run();
            end
            @(negedge clk);
        end
        check_word(imem_addr, mips_pkg::RESET_PC, "first fetch address");
    endtask

    // architectural reference, one instruction per step, no delay slot
    task automatic run_model();
        mips_pkg::word_t      gpr [0:31];
        mips_pkg::word_t      pc;
        mips_pkg::word_t      instr;
        mips_pkg::word_t      a;
        mips_pkg::word_t      b;
        mips_pkg::word_t      sext;
        mips_pkg::word_t      val;
        mips_pkg::word_t      next_pc;
        mips_pkg::reg_addr_t  dst;
        logic                 writes;
        int                   steps;
        exp_pc.delete();
        exp_wen.delete();
        exp_waddr.delete();
        exp_wdata.delete();
        exp_flushes = 0;
        for (int i = 0; i < 32; i++) begin
            gpr[i] = '0;
        end
        pc = mips_pkg::RESET_PC;
        steps = 0;
        while (((pc - mips_pkg::RESET_PC) >> 2) < prog_len) begin
            instr   = i_imem.mem[(pc - mips_pkg::RESET_PC) >> 2];
            a       = gpr[instr[25:21]];
            b       = gpr[instr[20:16]];
            sext    = {{16{instr[15]}}, instr[15:0]};
            next_pc = pc + 32'd4;
            dst     = instr[20:16];
            writes  = 1'b1;
            val     = '0;
            case (instr[31:26])
                mips_pkg::OP_SPECIAL: begin
                    dst = instr[15:11];
                    case (instr[5:0])
                        mips_pkg::FN_ADDU: val = a + b;
                        mips_pkg::FN_SUBU: val = a - b;
                        mips_pkg::FN_AND:  val = a & b;
                        mips_pkg::FN_OR:   val = a | b;
                        mips_pkg::FN_XOR:  val = a ^ b;
                        mips_pkg::FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:           writes = 1'b0;
                    endcase
                end
                mips_pkg::OP_ADDIU: val = a + sext;
                mips_pkg::OP_ORI:   val = a | {16'h0000, instr[15:0]};
                mips_pkg::OP_LUI:   val = {instr[15:0], 16'h0000};
                mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                    writes = 1'b0;
                    if ((a == b) == (instr[31:26] == mips_pkg::OP_BEQ)) begin
                        next_pc = pc + 32'd4 + (sext << 2);
                        exp_flushes++;
                    end
                end
                default: writes = 1'b0;
            endcase
            // r0 is hardwired
            if (dst == 5'd0) begin
                writes = 1'b0;
            end
            if (writes) begin
                gpr[dst] = val;
            end
            exp_pc.push_back(pc);
            exp_wen.push_back(writes);
            exp_waddr.push_back(dst);
            exp_wdata.push_back(val);
            pc = next_pc;
            steps++;
            if (steps > 2000) begin
                $display("ISA model did not leave the program within 2000 steps");
                abort_run();
            end
        end
    endtask

    task automatic wait_retire(input mips_pkg::word_t pc);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!rt_valid) begin
            cycles++;
            if (cycles > 60) begin
                $display("timeout: instruction at pc %h never retired", pc);
                abort_run();
            end
            @(negedge clk);
        end
    endtask

    task automatic compare_retires();
        for (int i = 0; i < exp_pc.size(); i++) begin
            wait_retire(exp_pc[i]);
            check_word(rt_pc, exp_pc[i], "retired pc");
            check_bit(rf_wen, exp_wen[i], $sformatf("rf_wen at pc %h", exp_pc[i]));
            if (exp_wen[i]) begin
                check_reg(rf_waddr, exp_waddr[i], $sformatf("rf_waddr at pc %h", exp_pc[i]));
                check_word(rf_wdata, exp_wdata[i], $sformatf("rf_wdata at pc %h", exp_pc[i]));
            end
        end
        check_word(mips_pkg::word_t'(flush_count), mips_pkg::word_t'(exp_flushes),
                   "flush_ex pulse count");
    endtask

    task automatic run_program(input int lat);
        i_imem.max_lat = lat;
        run_model();
        reset_dut();
        compare_retires();
    endtask

    // dependent R-type chain, operands seeded by ADDIU
    task automatic alu_chain_test(input int lat);
        clear_memory();
        emit(itype_word(mips_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h0005));
        emit(itype_word(mips_pkg::OP_ADDIU, 5'd2, 5'd0, 16'hfffd));
        emit(rtype_word(mips_pkg::FN_ADDU, 5'd3, 5'd1, 5'd2));
        emit(rtype_word(mips_pkg::FN_SUBU, 5'd4, 5'd3, 5'd1));
        emit(rtype_word(mips_pkg::FN_AND, 5'd5, 5'd4, 5'd3));
        emit(rtype_word(mips_pkg::FN_OR, 5'd6, 5'd5, 5'd2));
        emit(rtype_word(mips_pkg::FN_XOR, 5'd7, 5'd6, 5'd4));
        emit(rtype_word(mips_pkg::FN_SLT, 5'd8, 5'd2, 5'd1));
        emit(rtype_word(mips_pkg::FN_SLT, 5'd9, 5'd1, 5'd2));
        emit(rtype_word(mips_pkg::FN_ADDU, 5'd10, 5'd8, 5'd7));
        run_program(lat);
    endtask

    task automatic immediate_test();
        clear_memory();
        emit(itype_word(mips_pkg::OP_ADDIU, 5'd1, 5'd0, 16'hff9c));
        emit(itype_word(mips_pkg::OP_ORI, 5'd2, 5'd0, 16'h8001));
        emit(itype_word(mips_pkg::OP_LUI, 5'd3, 5'd0, 16'h1234));
        emit(itype_word(mips_pkg::OP_ORI, 5'd3, 5'd3, 16'habcd));
        emit(itype_word(mips_pkg::OP_ADDIU, 5'd4, 5'd3, 16'h8000));
        emit(itype_word(mips_pkg::OP_ORI, 5'd5, 5'd1, 16'h0f0f));
        run_program(1);
    endtask

    // counted loop on BNE, then forward BEQ/BNE taken and not taken
    task automatic branch_test(input int lat);
        clear_memory();
        emit(itype_word(mips_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h0003));
        emit(itype_word(mips_pkg::OP_ADDIU, 5'd2, 5'd0, 16'h0000));
        emit(itype_word(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0007));
        emit(itype_word(mips_pkg::OP_ADDIU, 5'd1, 5'd1, 16'hffff));
        emit(itype_word(mips_pkg::OP_BNE, 5'd0, 5'd1, 16'hfffd));
        emit(itype_word(mips_pkg::OP_BEQ, 5'd0, 5'd1, 16'h0002));
        // skipped by the BEQ above
        emit(itype_word(mips_pkg::OP_ADDIU, 5'd3, 5'd0, 16'h0111));
        emit(itype_word(mips_pkg::OP_ADDIU, 5'd3, 5'd0, 16'h0222));
        emit(itype_word(mips_pkg::OP_BEQ, 5'd0, 5'd2, 16'h0001));
        emit(itype_word(mips_pkg::OP_BNE, 5'd2, 5'd2, 16'h0001));
        emit(itype_word(mips_pkg::OP_ADDIU, 5'd4, 5'd2, 16'h0001));
        emit(itype_word(mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'h0001));
        emit(itype_word(mips_pkg::OP_ADDIU, 5'd5, 5'd0, 16'h0333));
        emit(rtype_word(mips_pkg::FN_OR, 5'd6, 5'd4, 5'd2));
        run_program(lat);
    endtask

    task automatic r0_test();
        clear_memory();
        emit(itype_word(mips_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h0009));
        emit(itype_word(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h0037));
        emit(rtype_word(mips_pkg::FN_ADDU, 5'd0, 5'd1, 5'd1));
        emit(itype_word(mips_pkg::OP_LUI, 5'd0, 5'd0, 16'hffff));
        // lw and mult encodings
        emit(32'h8c22_0004);
        emit(rtype_word(6'h18, 5'd3, 5'd1, 5'd1));
        emit(rtype_word(mips_pkg::FN_ADDU, 5'd4, 5'd0, 5'd1));
        emit(rtype_word(mips_pkg::FN_OR, 5'd5, 5'd0, 5'd0));
        run_program(2);
    endtask

    // registers limited to r0..r7 so dependencies are dense
    task automatic random_test();
        mips_pkg::reg_addr_t  rd;
        mips_pkg::reg_addr_t  rs;
        mips_pkg::reg_addr_t  rt;
        logic [15:0]          imm;
        mips_pkg::word_t      w;
        clear_memory();
        for (int i = 0; i < 200; i++) begin
            rd  = 5'($urandom % 8);
            rs  = 5'($urandom % 8);
            rt  = 5'($urandom % 8);
            imm = 16'($urandom);
            case ($urandom % 9)
                0:       w = rtype_word(mips_pkg::FN_ADDU, rd, rs, rt);
                1:       w = rtype_word(mips_pkg::FN_SUBU, rd, rs, rt);
                2:       w = rtype_word(mips_pkg::FN_AND, rd, rs, rt);
                3:       w = rtype_word(mips_pkg::FN_OR, rd, rs, rt);
                4:       w = rtype_word(mips_pkg::FN_XOR, rd, rs, rt);
                5:       w = rtype_word(mips_pkg::FN_SLT, rd, rs, rt);
                6:       w = itype_word(mips_pkg::OP_ADDIU, rd, rs, imm);
                7:       w = itype_word(mips_pkg::OP_ORI, rd, rs, imm);
                default: w = itype_word(mips_pkg::OP_LUI, rd, 5'd0, imm);
            endcase
            emit(w);
        end
        run_program(4);
    endtask

    initial begin
        void'($urandom(32'h96a2));
        clk         = 1'b0;
        rst_n       = 1'b0;
        prog_len    = 0;
        flush_count = 0;
        alu_chain_test(1);
        alu_chain_test(4);
        immediate_test();
        branch_test(1);
        branch_test(4);
        r0_test();
        random_test();
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== flist.f ====
common/mips_pkg.sv
common/issue_if.sv
common/retire_if.sv
fetch/fetch.sv
decode/decode.sv
execute/execute.sv
verilog/regfile.sv
verilog/datapath.sv
tb/imem_model.sv
tb/tb_datapath.sv
